//--- pf_pkg.sv
// ==============================
// shared types and layout constants for the playfield generator
// word, address, color and counter types, bpp codes, tile attribute union
// ==============================
package pf_pkg;

    typedef logic [15:0] word_t;            // vram data word
    typedef logic [15:0] addr_t;            // vram word address
    typedef logic [7:0]  color_t;           // color index
    typedef logic [10:0] hres_t;            // horizontal counter

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                  // 1 bpp with fore/back attribute
        BPP_4      = 2'd1,                  // 4 bpp, back nibble on top
        BPP_8      = 2'd2                   // 8 bpp, full index per byte
    } bpp_t;

    typedef struct packed {
        logic [3:0] back;                   // upper nibble for 4 bpp pixels
        logic       vrev;                   // vertical reverse
        logic       hrev;                   // horizontal reverse
        logic [9:0] index;                  // tile number
    } tile_entry_t;

    typedef struct packed {
        logic [3:0] back;                   // color for clear bits
        logic [3:0] fore;                   // color for set bits
        logic [7:0] code;                   // character code
    } text_cell_t;

    // one tilemap word, read as a tile entry or as a text cell depending on bpp
    typedef union packed {
        word_t       raw;
        tile_entry_t tile;
        text_cell_t  text;
    } tile_attr_u;

    localparam int TILE_BANK_SHIFT  = 10;   // bank field lands on word 1K boundaries
    localparam int PIXELS_PER_GROUP = 8;    // pixels per fetched group
    localparam int PIXBUF_W         = 64;   // 8 pixels of 8 bits

endpackage

//--- pf_fetch.sv
// ==============================
// fetch FSM for bitmap and tiled modes
// vram address generation and tile address calculation
// four-word fetch buffer with words-ready strobe
// ==============================
module pf_fetch import pf_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,             // memory busy, hold everything
    input  logic       mem_fetch_start_i,   // begin fetching this line
    input  logic       end_of_line_i,
    input  bpp_t       pf_bpp_i,
    input  logic       pf_bitmap_i,
    input  logic [5:0] pf_tile_bank_i,
    input  logic [3:0] pf_tile_height_i,    // bit 3 set means 16-line cells
    input  logic       buf_full_i,          // expander still holds a group
    input  addr_t      line_start_i,
    input  logic [3:0] tile_y_i,            // row inside tile cell
    input  word_t      vram_data_i,
    output logic       vram_sel_o,
    output addr_t      vram_addr_o,
    output logic       words_ready_o,       // one cycle, group complete
    output tile_attr_u attr_word_o,
    output word_t      data_word0_o,
    output word_t      data_word1_o,
    output word_t      data_word2_o,
    output word_t      data_word3_o
);

    typedef enum logic [3:0] {
        FETCH_IDLE, BM_ADDR, BM_WAIT, BM_READ0, BM_READ1, BM_READ2, BM_READ3,
        TM_ADDR, TM_WAIT, TM_READ, TL_WAIT, TL_READ0, TL_READ1
    } fetch_st_t;

    fetch_st_t  state, state_next;
    addr_t      pf_addr, addr_next;         // next display word to fetch
    addr_t      fetch_addr_next;
    addr_t      tile_addr;
    addr_t      bank_base;
    logic       sel_next;
    logic       ready_next;
    logic       start_ok;                   // room for a new group
    logic [2:0] row4;                       // 4 bpp tile row after vrev
    tile_attr_u map_word;                   // tilemap word as it arrives
    tile_attr_u attr_next;
    word_t      word0_next, word1_next, word2_next, word3_next;

    always_comb begin
        map_word  = vram_data_i;
        bank_base = addr_t'(pf_tile_bank_i) << TILE_BANK_SHIFT;
        row4      = map_word.tile.vrev ? ~tile_y_i[2:0] : tile_y_i[2:0];
        if (pf_bpp_i == BPP_1_ATTR) begin   // 4 or 8 words per char, two rows per word
            tile_addr = bank_base + (pf_tile_height_i[3] ? addr_t'(map_word.text.code) << 3
                                                         : addr_t'(map_word.text.code) << 2)
                      + addr_t'(tile_y_i[3:1]);
        end else begin                      // 16 words per tile, two per row
            tile_addr = bank_base + (addr_t'(map_word.tile.index) << 4) + addr_t'({row4, 1'b0});
        end
    end

    always_comb begin
        state_next      = state;
        addr_next       = pf_addr;
        fetch_addr_next = vram_addr_o;
        sel_next        = 1'b0;
        ready_next      = 1'b0;
        attr_next       = attr_word_o;
        word0_next      = data_word0_o;
        word1_next      = data_word1_o;
        word2_next      = data_word2_o;
        word3_next      = data_word3_o;
        start_ok        = !buf_full_i && !words_ready_o;    // last group not yet latched otherwise

        case (state)
            BM_ADDR, TM_ADDR: begin
                if (start_ok) begin
                    sel_next        = 1'b1;
                    fetch_addr_next = pf_addr;
                    addr_next       = pf_addr + 1'b1;
                    state_next      = (state == BM_ADDR) ? BM_WAIT : TM_WAIT;
                end
            end
            BM_WAIT: begin                  // bitmap always needs a second word
                sel_next        = 1'b1;
                fetch_addr_next = pf_addr;
                addr_next       = pf_addr + 1'b1;
                state_next      = BM_READ0;
            end
            BM_READ0: begin
                word0_next = vram_data_i;
                if (pf_bpp_i != BPP_4) begin
                    sel_next        = 1'b1;
                    fetch_addr_next = pf_addr;
                    addr_next       = pf_addr + 1'b1;
                end
                state_next = BM_READ1;
            end
            BM_READ1: begin
                word1_next = vram_data_i;
                if (pf_bpp_i == BPP_4) begin
                    ready_next = 1'b1;
                    state_next = BM_ADDR;
                end else begin
                    sel_next        = 1'b1;
                    fetch_addr_next = pf_addr;
                    addr_next       = pf_addr + 1'b1;
                    state_next      = BM_READ2;
                end
            end
            BM_READ2: begin
                word2_next = vram_data_i;
                state_next = BM_READ3;
            end
            BM_READ3: begin
                word3_next = vram_data_i;
                ready_next = 1'b1;
                state_next = BM_ADDR;
            end
            TM_WAIT: state_next = TM_READ;
            TM_READ: begin                  // tile word 0 goes out as the map word arrives
                attr_next       = map_word;
                sel_next        = 1'b1;
                fetch_addr_next = tile_addr;
                state_next      = TL_WAIT;
            end
            TL_WAIT: begin
                if (pf_bpp_i != BPP_1_ATTR) begin
                    sel_next        = 1'b1;
                    fetch_addr_next = vram_addr_o + 1'b1;
                end
                state_next = TL_READ0;
            end
            TL_READ0: begin
                if (pf_bpp_i == BPP_1_ATTR) begin   // even row high byte, odd row low byte
                    word0_next = {8'h00, tile_y_i[0] ? vram_data_i[7:0] : vram_data_i[15:8]};
                    ready_next = 1'b1;
                    state_next = TM_ADDR;
                end else begin
                    word0_next = vram_data_i;
                    state_next = TL_READ1;
                end
            end
            TL_READ1: begin
                word1_next = vram_data_i;
                ready_next = 1'b1;
                state_next = TM_ADDR;
            end
            default: state_next = FETCH_IDLE;       // idle until the line fetch starts
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FETCH_IDLE;
            pf_addr       <= '0;
            vram_sel_o    <= 1'b0;
            vram_addr_o   <= '0;
            words_ready_o <= 1'b0;
        end else begin
            words_ready_o <= ready_next && !stall_i;    // repeats after the stall instead
            if (!stall_i) begin
                state       <= state_next;
                pf_addr     <= addr_next;
                vram_sel_o  <= sel_next;
                vram_addr_o <= fetch_addr_next;
            end
            if (mem_fetch_start_i) begin
                state   <= pf_bitmap_i ? BM_ADDR : TM_ADDR;
                pf_addr <= line_start_i;
            end
            if (end_of_line_i) begin
                state <= FETCH_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            attr_word_o  <= attr_next;
            data_word0_o <= word0_next;
            data_word1_o <= word1_next;
            data_word2_o <= word2_next;
            data_word3_o <= word3_next;
        end
    end

endmodule

//--- pf_expand.sv
// ==============================
// word to pixel expansion
// 8-pixel buffer, hrev flag and buffer-full flag
// ==============================
module pf_expand import pf_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                mem_fetch_start_i,
    input  logic                words_ready_i,
    input  logic                group_take_i,   // scanout loads the buffer now
    input  bpp_t                pf_bpp_i,
    input  logic                pf_bitmap_i,
    input  tile_attr_u          attr_word_i,
    input  word_t               data_word0_i,
    input  word_t               data_word1_i,
    input  word_t               data_word2_i,
    input  word_t               data_word3_i,
    output logic                buf_full_o,
    output logic [PIXBUF_W-1:0] pixbuf_o,
    output logic                pixbuf_hrev_o
);

    logic [PIXBUF_W-1:0] expanded;
    logic [31:0]         nibbles;               // words 0 and 1 as eight 4 bpp pixels
    logic [3:0]          back;
    logic                hrev;
    logic                full_q;

    always_comb begin
        nibbles = {data_word0_i, data_word1_i};
        back    = pf_bitmap_i ? 4'h0 : attr_word_i.tile.back;
        hrev    = !pf_bitmap_i && (pf_bpp_i != BPP_1_ATTR) && attr_word_i.tile.hrev;
        case (pf_bpp_i)
            BPP_1_ATTR: begin
                for (int i = 0; i < PIXELS_PER_GROUP; i++) begin   // bit 7 is leftmost
                    expanded[i*8 +: 8] = {4'h0, data_word0_i[i] ? attr_word_i.text.fore
                                                                : attr_word_i.text.back};
                end
            end
            BPP_4: begin
                for (int i = 0; i < PIXELS_PER_GROUP; i++) begin
                    expanded[i*8 +: 8] = {back, nibbles[i*4 +: 4]};
                end
            end
            default: expanded = {data_word0_i, data_word1_i, data_word2_i, data_word3_i};
        endcase
    end

    // take frees the buffer in the same cycle so the next group can start at once
    assign buf_full_o = full_q && !group_take_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_q        <= 1'b0;
            pixbuf_hrev_o <= 1'b0;
        end else if (mem_fetch_start_i) begin
            full_q <= 1'b0;                     // drop leftovers from last line
        end else if (words_ready_i) begin
            full_q        <= 1'b1;
            pixbuf_hrev_o <= hrev;
        end else if (group_take_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (words_ready_i) begin
            pixbuf_o <= expanded;
        end
    end

endmodule

//--- pf_scanout.sv
// ==============================
// scanout window and pixel shift register
// border, blank and colorbase output
// ==============================
module pf_scanout import pf_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  hres_t               h_count_i,
    input  hres_t               vid_left_i,
    input  hres_t               vid_right_i,
    input  logic                end_of_line_i,
    input  logic                pf_blank_i,
    input  color_t              border_color_i,
    input  color_t              pf_colorbase_i,
    input  logic [PIXBUF_W-1:0] pixbuf_i,
    input  logic                pixbuf_hrev_i,
    output logic                group_take_o,   // one cycle, buffer loaded
    output color_t              pf_color_index_o
);

    logic                scanout;               // inside the visible window
    logic [2:0]          col;                   // pixel within current group
    logic                start_hit;
    logic                stop_hit;
    logic [PIXBUF_W-1:0] pixels;                // top byte is on screen
    logic [PIXBUF_W-1:0] group_rev;

    always_comb begin
        start_hit    = (h_count_i == hres_t'(vid_left_i - 1'b1));   // one early, so pixel 0 is on time
        stop_hit     = (h_count_i == hres_t'(vid_right_i - 1'b1));
        group_take_o = !stop_hit && !end_of_line_i
                     && (start_hit || (scanout && col == 3'(PIXELS_PER_GROUP - 1)));
        for (int i = 0; i < PIXELS_PER_GROUP; i++) begin
            group_rev[i*8 +: 8] = pixbuf_i[(PIXELS_PER_GROUP - 1 - i)*8 +: 8];
        end
    end

    assign pf_color_index_o = (scanout && !pf_blank_i) ? pixels[PIXBUF_W-1 -: 8] ^ pf_colorbase_i
                                                       : border_color_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout <= 1'b0;
            col     <= '0;
        end else if (stop_hit || end_of_line_i) begin
            scanout <= 1'b0;
        end else if (start_hit) begin
            scanout <= 1'b1;
            col     <= '0;
        end else if (scanout) begin
            col <= col + 1'b1;                  // wraps every group
        end
    end

    always_ff @(posedge clk) begin
        if (group_take_o) begin
            pixels <= pixbuf_hrev_i ? group_rev : pixbuf_i;
        end else begin
            pixels <= {pixels[PIXBUF_W-9:0], border_color_i};   // border trails the last pixel
        end
    end

endmodule

//--- pf_line_ctrl.sv
// ==============================
// line start address and tile row per line and frame
// ==============================
module pf_line_ctrl import pf_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       end_of_line_i,
    input  logic       end_of_frame_i,
    input  logic       pf_blank_i,
    input  addr_t      pf_start_addr_i,
    input  word_t      pf_line_len_i,
    input  logic       pf_bitmap_i,
    input  logic [3:0] pf_tile_height_i,    // last row of a tile cell
    output addr_t      line_start_o,
    output logic [3:0] tile_y_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start_o <= '0;
            tile_y_o     <= '0;
        end else if (end_of_frame_i || pf_blank_i) begin    // restart at top of display
            line_start_o <= pf_start_addr_i;
            tile_y_o     <= '0;
        end else if (end_of_line_i) begin
            if (pf_bitmap_i || tile_y_o >= pf_tile_height_i) begin
                tile_y_o     <= '0;
                line_start_o <= line_start_o + pf_line_len_i;   // wraps in 64K
            end else begin
                tile_y_o <= tile_y_o + 1'b1;    // same map row, next cell line
            end
        end
    end

endmodule

//--- video_playfield.sv
// ==============================
// playfield top level
// fetch, expand, scanout and line control
// ==============================
module video_playfield import pf_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,
    input  hres_t      h_count_i,
    input  logic       mem_fetch_start_i,
    input  logic       end_of_line_i,
    input  logic       end_of_frame_i,
    input  color_t     border_color_i,
    input  hres_t      vid_left_i,
    input  hres_t      vid_right_i,
    input  logic       pf_blank_i,
    input  addr_t      pf_start_addr_i,
    input  word_t      pf_line_len_i,
    input  color_t     pf_colorbase_i,
    input  bpp_t       pf_bpp_i,
    input  logic       pf_bitmap_i,
    input  logic [5:0] pf_tile_bank_i,
    input  logic [3:0] pf_tile_height_i,
    input  word_t      vram_data_i,
    output logic       vram_sel_o,
    output addr_t      vram_addr_o,
    output color_t     pf_color_index_o
);

    logic                words_ready;
    tile_attr_u          attr_word;
    word_t               data_word0, data_word1, data_word2, data_word3;
    logic                buf_full;          // back-pressure to fetch
    logic [PIXBUF_W-1:0] pixbuf;
    logic                pixbuf_hrev;
    logic                group_take;
    addr_t               line_start;
    logic [3:0]          tile_y;

    pf_fetch fetch_i (
        .clk, .reset_i, .stall_i, .mem_fetch_start_i, .end_of_line_i,
        .pf_bpp_i, .pf_bitmap_i, .pf_tile_bank_i, .pf_tile_height_i,
        .buf_full_i(buf_full), .line_start_i(line_start), .tile_y_i(tile_y), .vram_data_i,
        .vram_sel_o, .vram_addr_o, .words_ready_o(words_ready), .attr_word_o(attr_word),
        .data_word0_o(data_word0), .data_word1_o(data_word1),
        .data_word2_o(data_word2), .data_word3_o(data_word3)
    );

    pf_expand expand_i (
        .clk, .reset_i, .mem_fetch_start_i, .words_ready_i(words_ready),
        .group_take_i(group_take), .pf_bpp_i, .pf_bitmap_i, .attr_word_i(attr_word),
        .data_word0_i(data_word0), .data_word1_i(data_word1),
        .data_word2_i(data_word2), .data_word3_i(data_word3),
        .buf_full_o(buf_full), .pixbuf_o(pixbuf), .pixbuf_hrev_o(pixbuf_hrev)
    );

    pf_scanout scanout_i (
        .clk, .reset_i, .h_count_i, .vid_left_i, .vid_right_i, .end_of_line_i,
        .pf_blank_i, .border_color_i, .pf_colorbase_i,
        .pixbuf_i(pixbuf), .pixbuf_hrev_i(pixbuf_hrev),
        .group_take_o(group_take), .pf_color_index_o
    );

    pf_line_ctrl line_ctrl_i (
        .clk, .reset_i, .end_of_line_i, .end_of_frame_i, .pf_blank_i,
        .pf_start_addr_i, .pf_line_len_i, .pf_bitmap_i, .pf_tile_height_i,
        .line_start_o(line_start), .tile_y_o(tile_y)
    );

endmodule

//--- video_playfield_sva.sv
// ==============================
// fetch protocol assertions, bound into pf_fetch
// ==============================
module fetch_sva (
    input logic        clk,
    input logic        reset_i,
    input logic        stall_i,
    input logic        buf_full_i,
    input logic        vram_sel_o,
    input logic [15:0] vram_addr_o,
    input logic        words_ready_o
);

    stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        stall_i |=> $stable(vram_sel_o) && $stable(vram_addr_o))
        else $error("vram select or address moved during a stall");

    no_start_when_full: assert property (@(posedge clk) disable iff (reset_i)
        buf_full_i |=> !$rose(vram_sel_o))
        else $error("new group started while the pixel buffer was full");

    ready_pulse: assert property (@(posedge clk) disable iff (reset_i)
        words_ready_o |=> !words_ready_o)
        else $error("words ready held longer than one cycle");

endmodule

bind pf_fetch fetch_sva fetch_sva_i (
    .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .buf_full_i(buf_full_i),
    .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .words_ready_o(words_ready_o)
);

//--- tb_video_playfield.sv
// ==============================
// playfield testbench: clock, reset, vram model, stall source
// case driver from playfield_cases.txt and reference pixel model
// ==============================
module tb_video_playfield import pf_pkg::*; ();

    localparam int MAX_CASES = 32;

    logic clk, reset_i, mem_fetch_start_i, end_of_line_i, end_of_frame_i, pf_blank_i;
    logic stall_i = 1'b0;
    logic pf_bitmap_i, vram_sel_o;
    hres_t h_count_i, vid_left_i, vid_right_i;
    color_t border_color_i, pf_colorbase_i, pf_color_index_o;
    addr_t pf_start_addr_i, vram_addr_o;
    word_t pf_line_len_i;
    word_t vram_data_i = '0;
    bpp_t pf_bpp_i;
    logic [5:0] pf_tile_bank_i;
    logic [3:0] pf_tile_height_i;

    word_t vram [0:65535];                      // whole 64K word video memory
    int c_bitmap[MAX_CASES], c_bpp[MAX_CASES], c_bank[MAX_CASES], c_start[MAX_CASES];
    int c_len[MAX_CASES], c_height[MAX_CASES], c_cbase[MAX_CASES], c_left[MAX_CASES];
    int c_right[MAX_CASES], c_lines[MAX_CASES], c_stall[MAX_CASES], c_expect[MAX_CASES];
    int num_cases = 0, mismatches = 0, other_errors = 0, visible = 0;
    int cycles = 0, cycle_limit = 1000, stall_gap = 0;
    logic check_en = 1'b0, in_line = 1'b0, stall_en = 1'b0;
    addr_t ref_ls;                              // line start the reference expects
    logic [3:0] ref_ty;                         // tile row the reference expects

    video_playfield dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin                 // registered read on select, data held while stalled
        if (!stall_i && vram_sel_o) vram_data_i <= vram[vram_addr_o];
    end

    always @(posedge clk) begin                 // at most one stall in any 8 cycles
        if (stall_en && stall_gap >= 7 && ($urandom % 2) == 0) begin
            stall_i   <= 1'b1;
            stall_gap <= 0;
        end else begin
            stall_i   <= 1'b0;
            stall_gap <= stall_gap + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // expected color of visible column x, before colorbase
    function automatic color_t predict_pixel(int x);
        addr_t a;
        word_t w, w1;
        tile_attr_u m;
        logic [7:0] b;
        logic [2:0] row;
        int p, n;
        color_t pix;
        p = x % 8;
        if (pf_bitmap_i && pf_bpp_i == BPP_8) begin      // two pixels per word
            w   = vram[ref_ls + addr_t'(x / 2)];
            pix = (x % 2 == 0) ? w[15:8] : w[7:0];
        end else if (pf_bitmap_i) begin                  // four nibbles per word
            w   = vram[ref_ls + addr_t'(x / 4)];
            pix = {4'h0, w[15 - 4 * (x % 4) -: 4]};
        end else begin
            m.raw = vram[ref_ls + addr_t'(x / 8)];       // one map word per group
            a = addr_t'(int'(pf_tile_bank_i) * 1024);
            if (pf_bpp_i == BPP_1_ATTR) begin
                a   = a + addr_t'(int'(m.text.code) * ((pf_tile_height_i >= 4'd8) ? 8 : 4))
                    + addr_t'(ref_ty / 2);
                w   = vram[a];
                b   = ref_ty[0] ? w[7:0] : w[15:8];      // odd rows in the low byte
                pix = {4'h0, b[7 - p] ? m.text.fore : m.text.back};
            end else begin
                row = m.tile.vrev ? 3'(7 - ref_ty[2:0]) : ref_ty[2:0];
                a   = a + addr_t'(int'(m.tile.index) * 16) + addr_t'(int'(row) * 2);
                n   = m.tile.hrev ? 7 - p : p;
                w   = vram[a];
                w1  = vram[a + 16'd1];
                pix = {m.tile.back, (n < 4) ? w[15 - 4 * n -: 4] : w1[15 - 4 * (n - 4) -: 4]};
            end
        end
        return pix;
    endfunction

    always @(negedge clk) begin : check_pixels
        color_t expected;
        logic   in_window;
        if (check_en) begin
            in_window = in_line && !pf_blank_i && h_count_i >= vid_left_i
                        && h_count_i < vid_right_i;
            if (in_window) begin
                expected = predict_pixel(int'(h_count_i - vid_left_i)) ^ pf_colorbase_i;
            end else begin
                expected = border_color_i;      // border outside window and while blanked
            end
            assert (pf_color_index_o === expected) else begin
                mismatches++;
                $display("mismatch pf_color_index_o h_count=%h got=%h expected=%h",
                         h_count_i, pf_color_index_o, expected);
            end
            if (in_window && pf_color_index_o === expected) visible++;  // correct pixels only
        end
    end

    task automatic drive_line(input logic blank);
        int total;
        total = int'(vid_right_i) + 8;
        for (int h = 0; h < total; h++) begin
            @(posedge clk);
            in_line = 1'b1;
            h_count_i         <= hres_t'(h);
            mem_fetch_start_i <= (h == 0);
            end_of_line_i     <= (h == total - 1);
            pf_blank_i        <= blank;
        end
        @(posedge clk);                         // gap cycle, line control has advanced
        in_line = 1'b0;
        h_count_i     <= '0;
        end_of_line_i <= 1'b0;
        pf_blank_i    <= 1'b0;
        if (blank) begin
            ref_ls = pf_start_addr_i;
            ref_ty = '0;
        end else if (pf_bitmap_i || ref_ty >= pf_tile_height_i) begin
            ref_ty = '0;
            ref_ls = ref_ls + pf_line_len_i;
        end else begin
            ref_ty = ref_ty + 4'd1;
        end
    endtask

    task automatic run_case(input int k);
        @(posedge clk);
        pf_bitmap_i      <= (c_bitmap[k] != 0);
        pf_bpp_i         <= bpp_t'(2'(c_bpp[k]));
        pf_tile_bank_i   <= 6'(c_bank[k]);
        pf_start_addr_i  <= addr_t'(c_start[k]);
        pf_line_len_i    <= word_t'(c_len[k]);
        pf_tile_height_i <= 4'(c_height[k]);
        pf_colorbase_i   <= color_t'(c_cbase[k]);
        vid_left_i       <= hres_t'(c_left[k]);
        vid_right_i      <= hres_t'(c_right[k]);
        border_color_i   <= color_t'(k * 37 + 5);
        stall_en         <= (c_stall[k] != 0);
        end_of_frame_i   <= 1'b1;               // frame restart loads the start address
        ref_ls = addr_t'(c_start[k]);
        ref_ty = '0;
        visible = 0;
        @(posedge clk);
        end_of_frame_i <= 1'b0;
        for (int line = 0; line < c_lines[k]; line++) begin
            if (line == c_lines[k] - 1) drive_line(1'b1);  // blanking sends the last line to the top
            drive_line(1'b0);
        end
        assert (visible == c_expect[k]) else begin
            other_errors++;
            $display("case %0d showed %0d correct visible pixels but %0d were expected",
                     k, visible, c_expect[k]);
        end
    endtask

    initial begin : run
        int fd;
        string line;
        void'($urandom(48917));
        for (int a = 0; a < 65536; a++) vram[a] = word_t'($urandom);
        reset_i = 1'b1;
        mem_fetch_start_i = 1'b0;
        end_of_line_i = 1'b0;
        end_of_frame_i = 1'b0;
        pf_blank_i = 1'b0;
        h_count_i = '0;
        border_color_i = 8'h5a;
        pf_colorbase_i = '0;
        vid_left_i = 11'd32;
        vid_right_i = 11'd112;
        pf_start_addr_i = '0;
        pf_line_len_i = '0;
        pf_bpp_i = BPP_8;
        pf_bitmap_i = 1'b1;
        pf_tile_bank_i = '0;
        pf_tile_height_i = '0;
        fd = $fopen("playfield_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the case file playfield_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && num_cases < MAX_CASES &&
                    $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                        c_bitmap[num_cases], c_bpp[num_cases], c_bank[num_cases],
                        c_start[num_cases], c_len[num_cases], c_height[num_cases],
                        c_cbase[num_cases], c_left[num_cases], c_right[num_cases],
                        c_lines[num_cases], c_stall[num_cases], c_expect[num_cases]) == 12) begin
                    cycle_limit += (c_lines[num_cases] + 1) * (c_right[num_cases] + 9) + 2;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
        if (num_cases == 0) begin
            other_errors++;
            $display("no test cases were read");
        end
        @(posedge clk);
        check_en = 1'b1;                        // output is border from the first reset edge
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        for (int k = 0; k < num_cases; k++) run_case(k);
        @(posedge clk);
        $display("cases %0d, pixel mismatches %0d, other errors %0d",
                 num_cases, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- playfield_cases.txt
# bitmap bpp(0=1attr 1=4 2=8) bank start line_len tile_height colorbase
# left right lines stall expected_visible_pixels
1 2 0 100 40 0 0 32 112 3 0 240
1 2 0 65500 64 0 165 40 168 2 0 256
1 1 0 2000 20 0 0 32 96 3 0 192
1 1 0 300 17 0 90 30 102 2 0 144
0 0 5 4000 10 7 0 32 112 10 0 800
0 0 63 500 12 15 51 28 108 18 0 1440
0 1 2 8000 10 7 0 32 112 10 0 800
0 1 40 1234 9 7 200 36 100 9 0 576
1 2 0 700 40 0 3 32 112 3 1 240
1 1 0 900 20 0 0 32 96 3 1 192
0 0 7 3000 10 15 0 32 112 17 1 1360
0 1 9 5000 10 7 17 32 112 9 1 720

//--- flist.f
pf_pkg.sv
pf_fetch.sv
pf_expand.sv
pf_scanout.sv
pf_line_ctrl.sv
video_playfield.sv
video_playfield_sva.sv
tb_video_playfield.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the playfield testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_video_playfield -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
